// File: design/synth_pkg.sv
// Shared widths, MIDI codes, parameter map and bus types for the filter voice stage
// Imported by every design module of the low-pass filter
package synth_pkg;

    // Widths
    localparam int SAMPLE_W    = 18;  // Audio sample width
    localparam int COEF_W      = 8;   // Parameter value width, 1..128
    localparam int MIDI_DATA_W = 7;
    localparam int MIDI_CH_W   = 4;
    localparam int NUM_PARAMS  = 2;   // Alpha and gain
    localparam int COEF_SHIFT  = 7;   // Fraction bits of a coefficient

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [SAMPLE_W:0]   diff_t;      // One bit wider than a sample
    typedef logic [MIDI_DATA_W-1:0]     midi_data_t;
    typedef logic [MIDI_CH_W-1:0]       midi_ch_t;
    typedef logic [COEF_W-1:0]          coef_t;      // Read as value/128
    typedef logic [0:0]                 param_addr_t;

    // Decoded command from the MIDI front end
    typedef enum logic [2:0] {
        CMD_NOTE_OFF     = 3'd0,
        CMD_NOTE_ON      = 3'd1,
        CMD_POLY_AT      = 3'd2,
        CMD_CTRL_CHANGE  = 3'd3,
        CMD_PROG_CHANGE  = 3'd4,
        CMD_CHAN_AT      = 3'd5,
        CMD_PITCH_BEND   = 3'd6,
        CMD_SYSTEM       = 3'd7
    } midi_cmd_t;

    localparam midi_ch_t    LPF_MIDI_CH  = 4'd0;
    localparam midi_data_t  CC_CUTOFF    = 7'd74;  // Brightness controller
    localparam midi_data_t  CC_LEVEL     = 7'd7;   // Channel volume
    localparam param_addr_t ADDR_ALPHA   = 1'b0;
    localparam param_addr_t ADDR_GAIN    = 1'b1;
    localparam coef_t       COEF_DEFAULT = 8'd128; // Pass-through

    // One master's request on the parameter bus
    typedef struct packed {
        logic        req;
        logic        write;
        param_addr_t addr;
        coef_t       wdata;
    } param_req_t;

    // Granted request as seen by the register file
    typedef struct packed {
        logic        req;
        logic        write;
        param_addr_t addr;
        coef_t       wdata;
    } param_bus_t;

endpackage

// File: design/midi_cc_decoder.sv
// Control-change decoder for the filter channel
// Turns cutoff and level controllers into parameter-bus write requests
`timescale 1ns/1ps

module midi_cc_decoder import synth_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       midi_rdy,      // One-cycle message strobe
    input  midi_cmd_t  midi_cmd,
    input  midi_ch_t   midi_ch_sysn,
    input  midi_data_t midi_data0,    // Controller number
    input  midi_data_t midi_data1,    // Controller value
    input  logic       dec_gnt,
    output param_req_t dec_req
);

    logic  is_cc;       // Control change on our channel
    logic  is_cutoff;
    logic  is_level;
    logic  accept;      // Message turns into a write
    coef_t wr_value;

    assign is_cc     = (midi_cmd == CMD_CTRL_CHANGE) && (midi_ch_sysn == LPF_MIDI_CH);
    assign is_cutoff = (midi_data0 == CC_CUTOFF);
    assign is_level  = (midi_data0 == CC_LEVEL);
    assign accept    = midi_rdy && is_cc && (is_cutoff || is_level);

    // 0..127 maps onto 1..128 so a full-scale value passes unchanged
    assign wr_value = {1'b0, midi_data1} + coef_t'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_req <= '0;
        end else if (dec_req.req) begin
            if (dec_gnt) begin
                dec_req.req <= 1'b0;                // Write lands this edge
            end
            // New messages dropped while pending
        end else if (accept) begin
            dec_req.req   <= 1'b1;
            dec_req.write <= 1'b1;
            dec_req.addr  <= is_cutoff ? ADDR_ALPHA : ADDR_GAIN;
            dec_req.wdata <= wr_value;
        end
    end

endmodule

// File: design/param_arbiter.sv
// Fixed-priority arbiter for the parameter bus
// The decoder wins over the filter core, grants are combinational from the requests
`timescale 1ns/1ps

module param_arbiter import synth_pkg::*; (
    input  param_req_t dec_req,
    input  param_req_t core_req,
    output logic       dec_gnt,
    output logic       core_gnt,
    output param_bus_t bus
);

    always_comb begin
        dec_gnt  = dec_req.req;                    // Highest priority
        core_gnt = core_req.req && !dec_req.req;   // Only when decoder idle

        // Forward the winner's fields
        if (dec_req.req) begin
            bus.write = dec_req.write;
            bus.addr  = dec_req.addr;
            bus.wdata = dec_req.wdata;
        end else begin
            bus.write = core_req.write;
            bus.addr  = core_req.addr;
            bus.wdata = core_req.wdata;
        end

        bus.req = dec_gnt || core_gnt;             // High only in granted cycles
    end

endmodule

// File: design/param_regs.sv
// Register file for the filter parameters, cutoff coefficient and output gain
// Writes land at the end of the granted cycle, reads return one cycle later
`timescale 1ns/1ps

module param_regs import synth_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  param_bus_t bus,
    output coef_t      rdata      // Valid the cycle after a granted read
);

    coef_t regs_q [NUM_PARAMS];   // Indexed by ADDR_ALPHA / ADDR_GAIN

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PARAMS; i++) begin
                regs_q[i] <= COEF_DEFAULT;    // Start as pass-through
            end
        end else if (bus.req && bus.write) begin
            regs_q[bus.addr] <= bus.wdata;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (bus.req && !bus.write) begin
            rdata <= regs_q[bus.addr];
        end
    end

endmodule

// File: design/lpf_core.sv
// One-pole low-pass filter core with output gain
// Fetches alpha and gain over the parameter bus for every sample, one sample in flight
`timescale 1ns/1ps

module lpf_core import synth_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sample_in_rdy,   // Ignored unless idle
    input  sample_t    sample_in,
    input  logic       core_gnt,
    input  coef_t      rdata,
    output param_req_t core_req,
    output logic       sample_out_rdy,  // One-cycle result strobe
    output sample_t    sample_out
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ALPHA,    // Alpha read on the bus
        ST_WAIT_ALPHA,  // Alpha on rdata
        ST_RD_GAIN,
        ST_WAIT_GAIN,   // Gain on rdata, filter step
        ST_OUTPUT       // Gain product
    } state_t;

    state_t state;
    sample_t x_q;       // Captured input
    sample_t y_q;       // Filter state
    coef_t   alpha_q;
    coef_t   gain_q;

    diff_t                             diff;
    logic signed [SAMPLE_W+COEF_W+1:0] step_prod;  // diff * alpha
    logic signed [SAMPLE_W+COEF_W+1:0] step_full;
    sample_t                           y_next;
    logic signed [SAMPLE_W+COEF_W:0]   out_prod;   // y * gain
    logic signed [SAMPLE_W+COEF_W:0]   out_full;

    // Read requests follow the state, so they stay stable until granted
    always_comb begin
        core_req       = '0;
        core_req.req   = (state == ST_RD_ALPHA) || (state == ST_RD_GAIN);
        core_req.write = 1'b0;
        core_req.addr  = (state == ST_RD_GAIN) ? ADDR_GAIN : ADDR_ALPHA;
    end

    // y + ((x - y) * alpha) >>> 7, result always between x and y
    assign diff      = {x_q[SAMPLE_W-1], x_q} - {y_q[SAMPLE_W-1], y_q};
    assign step_prod = diff * $signed({1'b0, alpha_q});
    assign step_full = step_prod >>> COEF_SHIFT;       // Rounds toward -inf
    assign y_next    = y_q + step_full[SAMPLE_W-1:0];

    // Gain at most 128, no overflow
    assign out_prod = y_q * $signed({1'b0, gain_q});
    assign out_full = out_prod >>> COEF_SHIFT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            y_q            <= '0;
            sample_out     <= '0;
            sample_out_rdy <= 1'b0;
        end else begin
            sample_out_rdy <= 1'b0;
            case (state)
                ST_IDLE:       if (sample_in_rdy) state <= ST_RD_ALPHA;
                ST_RD_ALPHA:   if (core_gnt) state <= ST_WAIT_ALPHA;  // Decoder may stall us
                ST_WAIT_ALPHA: state <= ST_RD_GAIN;
                ST_RD_GAIN:    if (core_gnt) state <= ST_WAIT_GAIN;
                ST_WAIT_GAIN: begin
                    y_q   <= y_next;
                    state <= ST_OUTPUT;
                end
                ST_OUTPUT: begin
                    sample_out     <= out_full[SAMPLE_W-1:0];
                    sample_out_rdy <= 1'b1;
                    state          <= ST_IDLE;
                end
                default:       state <= ST_IDLE;
            endcase
        end
    end

    // Payload captures
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && sample_in_rdy) x_q <= sample_in;
        if (state == ST_WAIT_ALPHA) alpha_q <= rdata;
        if (state == ST_WAIT_GAIN) gain_q <= rdata;
    end

endmodule

// File: design/lpf_top.sv
// Low-pass filter voice stage, MIDI control-change in, filtered samples out
// Decoder and core share the parameter register file through the arbiter
`timescale 1ns/1ps

module lpf_top import synth_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       midi_rdy,
    input  midi_cmd_t  midi_cmd,
    input  midi_ch_t   midi_ch_sysn,
    input  midi_data_t midi_data0,
    input  midi_data_t midi_data1,
    input  logic       sample_in_rdy,
    input  sample_t    sample_in,
    output logic       sample_out_rdy,
    output sample_t    sample_out
);

    param_req_t dec_req;
    param_req_t core_req;
    logic       dec_gnt;
    logic       core_gnt;
    param_bus_t bus;       // Granted request to the register file
    coef_t      rdata;

    midi_cc_decoder midi_cc_decoder_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .midi_rdy     (midi_rdy),
        .midi_cmd     (midi_cmd),
        .midi_ch_sysn (midi_ch_sysn),
        .midi_data0   (midi_data0),
        .midi_data1   (midi_data1),
        .dec_gnt      (dec_gnt),
        .dec_req      (dec_req)
    );

    param_arbiter param_arbiter_i (
        .dec_req  (dec_req),
        .core_req (core_req),
        .dec_gnt  (dec_gnt),
        .core_gnt (core_gnt),
        .bus      (bus)
    );

    param_regs param_regs_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus),
        .rdata (rdata)
    );

    lpf_core lpf_core_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .core_gnt       (core_gnt),
        .rdata          (rdata),
        .core_req       (core_req),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out)
    );

endmodule

// File: tests/lpf_top_sva.sv
// Protocol assertions for the filter voice stage
// Bound into lpf_top to watch the parameter bus requests and the sample strobes
`timescale 1ns/1ps

module lpf_top_sva import synth_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       sample_in_rdy,
    input logic       sample_out_rdy,
    input param_req_t dec_req,
    input param_req_t core_req,
    input logic       dec_gnt,
    input logic       core_gnt
);

    logic       busy;     // Sample in flight in the core
    logic [4:0] cycles;   // Edges since the sample was accepted

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            cycles <= '0;
        end else if (sample_in_rdy && (!busy || sample_out_rdy)) begin
            busy   <= 1'b1;               // Core idle again once the result strobe is out
            cycles <= '0;
        end else if (busy) begin
            if (sample_out_rdy) begin
                busy <= 1'b0;
            end else begin
                cycles <= cycles + 5'd1;
            end
        end
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(dec_gnt && core_gnt))
        else $error("dec_gnt and core_gnt high together");

    a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dec_req.req && !dec_gnt |=> dec_req.req && $stable(dec_req))
        else $error("dec_req dropped or changed before its grant");

    a_core_hold: assert property (@(posedge clk) disable iff (!rst_n)
        core_req.req && !core_gnt |=> core_req.req && $stable(core_req))
        else $error("core_req dropped or changed before its grant");

    a_out_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sample_out_rdy |=> !sample_out_rdy)
        else $error("sample_out_rdy high for two cycles");

    // Result due within 12 cycles of acceptance
    a_out_latency: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> cycles <= 5'd12)
        else $error("no sample_out_rdy within 12 cycles of sample_in_rdy");

endmodule

bind lpf_top lpf_top_sva lpf_top_sva_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_in_rdy  (sample_in_rdy),
    .sample_out_rdy (sample_out_rdy),
    .dec_req        (dec_req),
    .core_req       (core_req),
    .dec_gnt        (dec_gnt),
    .core_gnt       (core_gnt)
);

// File: tests/tb_lpf_top.sv
// Testbench for the low-pass filter voice stage
// Sends MIDI control changes and audio samples, checks sample_out against a reference model
`timescale 1ns/1ps

module tb_lpf_top import synth_pkg::*; ();

    logic       clk;
    logic       rst_n;
    logic       midi_rdy;
    midi_cmd_t  midi_cmd;
    midi_ch_t   midi_ch_sysn;
    midi_data_t midi_data0;
    midi_data_t midi_data1;
    logic       sample_in_rdy;
    sample_t    sample_in;
    logic       sample_out_rdy;
    sample_t    sample_out;

    int y_ref;          // Model filter state
    int alpha_ref;      // Model cutoff coefficient
    int gain_ref;       // Model output level
    int test_errs;      // Errors in the running test
    int tests_passed;
    int tests_failed;

    lpf_top lpf_top_i (.*);

    always #5 clk = ~clk;

    // One-pole step, arithmetic shift floors toward minus infinity
    function automatic int filter_step(input int y, input int x, input int alpha);
        return y + (((x - y) * alpha) >>> COEF_SHIFT);
    endfunction

    function automatic int apply_gain(input int y, input int gain);
        return (y * gain) >>> COEF_SHIFT;
    endfunction

    // Pulse midi_rdy and track the parameter the message should change
    task automatic send_midi(input midi_cmd_t cmd, input midi_ch_t ch,
                             input midi_data_t d0, input midi_data_t d1);
        @(posedge clk);
        #1;
        midi_cmd     = cmd;
        midi_ch_sysn = ch;
        midi_data0   = d0;
        midi_data1   = d1;
        midi_rdy     = 1'b1;
        @(posedge clk);
        #1;
        midi_rdy = 1'b0;
        if (cmd == CMD_CTRL_CHANGE && ch == LPF_MIDI_CH) begin
            if (d0 == CC_CUTOFF) alpha_ref = int'(d1) + 1;
            else if (d0 == CC_LEVEL) gain_ref = int'(d1) + 1;
        end
        repeat (3) @(posedge clk);    // Write lands within two edges
    endtask

    task automatic pulse_sample(input sample_t x);
        @(posedge clk);
        #1;
        sample_in     = x;
        sample_in_rdy = 1'b1;
        @(posedge clk);
        #1;
        sample_in_rdy = 1'b0;
    endtask

    task automatic wait_out(output bit seen);
        seen = 1'b0;
        for (int i = 0; i < 50 && !seen; i++) begin
            @(posedge clk);
            #1;                       // Outputs settled after the edge
            seen = sample_out_rdy;
        end
        assert (seen) else begin
            $display("Timeout at %0t, no sample_out_rdy within 50 cycles", $time);
            test_errs++;
        end
    endtask

    task automatic check_out(input int exp);
        assert (sample_out == sample_t'(exp)) else begin
            $display("FAILED at %0t: sample_out expected %0d actual %0d",
                     $time, exp, sample_out);
            test_errs++;
        end
    endtask

    task automatic run_sample(input sample_t x);
        bit seen;
        pulse_sample(x);
        y_ref = filter_step(y_ref, int'(x), alpha_ref);
        wait_out(seen);
        if (seen) check_out(apply_gain(y_ref, gain_ref));
    endtask

    task automatic end_test(input int num, input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("Test %0d %s: PASS", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL with %0d errors", num, name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        sample_t x;
        bit      seen;
        int      extra;
        int      old_alpha;
        int      exp_old;
        int      exp_new;
        int      y_old;
        int      y_new;
        void'($urandom(32'h5933_0a64));
        clk           = 1'b0;
        rst_n         = 1'b0;
        midi_rdy      = 1'b0;
        midi_cmd      = CMD_NOTE_OFF;
        midi_ch_sysn  = '0;
        midi_data0    = '0;
        midi_data1    = '0;
        sample_in_rdy = 1'b0;
        sample_in     = '0;
        y_ref         = 0;
        alpha_ref     = int'(COEF_DEFAULT);
        gain_ref      = int'(COEF_DEFAULT);
        test_errs     = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        repeat (10) run_sample(sample_t'($urandom));   // Defaults pass samples through
        end_test(1, "default pass-through");

        send_midi(CMD_CTRL_CHANGE, LPF_MIDI_CH, CC_CUTOFF, midi_data_t'($urandom_range(126, 0)));
        x = sample_t'($urandom);
        repeat (8) run_sample(x);                      // Step toward a constant input
        end_test(2, "cutoff step response");

        send_midi(CMD_CTRL_CHANGE, LPF_MIDI_CH, CC_LEVEL, midi_data_t'($urandom_range(127, 0)));
        repeat (6) run_sample(sample_t'($urandom));
        end_test(3, "output level");

        send_midi(CMD_CTRL_CHANGE, midi_ch_t'(5), CC_CUTOFF, 7'd3);
        send_midi(CMD_CTRL_CHANGE, midi_ch_t'(5), CC_LEVEL, 7'd9);
        send_midi(CMD_NOTE_ON, LPF_MIDI_CH, CC_CUTOFF, 7'd20);   // Not a control change
        send_midi(CMD_CTRL_CHANGE, LPF_MIDI_CH, midi_data_t'(10), 7'd50);
        repeat (6) run_sample(sample_t'($urandom));
        end_test(4, "ignored messages");

        send_midi(CMD_CTRL_CHANGE, LPF_MIDI_CH, CC_LEVEL, 7'd127);  // Unity gain, y visible
        old_alpha = alpha_ref;
        x         = sample_t'($urandom);
        pulse_sample(x);
        @(posedge clk);
        #1;
        midi_cmd     = CMD_CTRL_CHANGE;        // Two cycles after sample_in_rdy
        midi_ch_sysn = LPF_MIDI_CH;
        midi_data0   = CC_CUTOFF;
        midi_data1   = midi_data_t'($urandom_range(126, 0));
        midi_rdy     = 1'b1;
        @(posedge clk);
        #1;
        midi_rdy  = 1'b0;
        alpha_ref = int'(midi_data1) + 1;
        y_old     = filter_step(y_ref, int'(x), old_alpha);
        y_new     = filter_step(y_ref, int'(x), alpha_ref);
        exp_old   = apply_gain(y_old, gain_ref);
        exp_new   = apply_gain(y_new, gain_ref);
        wait_out(seen);
        if (seen) begin
            assert (sample_out == sample_t'(exp_old) || sample_out == sample_t'(exp_new))
            else begin
                $display("FAILED at %0t: sample_out expected %0d or %0d actual %0d",
                         $time, exp_old, exp_new, sample_out);
                test_errs++;
            end
            y_ref = (sample_out == sample_t'(exp_old)) ? y_old : y_new;
        end
        extra = 0;
        repeat (10) begin
            @(posedge clk);
            #1;
            if (sample_out_rdy) extra++;
        end
        assert (extra == 0) else begin
            $display("Extra sample_out_rdy pulses after one sample at %0t", $time);
            test_errs++;
        end
        run_sample(sample_t'($urandom));       // New alpha in effect
        end_test(5, "write during core reads");

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
design/synth_pkg.sv
design/midi_cc_decoder.sv
design/param_arbiter.sv
design/param_regs.sv
design/lpf_core.sv
design/lpf_top.sv
tests/lpf_top_sva.sv
tests/tb_lpf_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the low-pass filter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_lpf_top \
    -o sim_lpf

./obj_dir/sim_lpf | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run FAILED, see sim.log"
    exit 1
fi

echo "Run passed"
